/* sim.f */
+incdir+.
cpu8_pkg.sv
cpu8_bus_if.sv
cpu8_alu.sv
cpu8_control.sv
cpu8_memory.sv
cpu8_system.sv
cpu8_properties.sv
tb_cpu8_system.sv

/* Bender.yml */
package:
  name: cpu8

export_include_dirs:
  - .

sources:
  - cpu8_pkg.sv
  - cpu8_bus_if.sv
  - cpu8_alu.sv
  - cpu8_control.sv
  - cpu8_memory.sv
  - cpu8_system.sv
  - target: test
    files:
      - cpu8_properties.sv
      - tb_cpu8_system.sv

/* tb_cpu8_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

module tb_cpu8_system;

  localparam int clk_period = 4;
  localparam int budget = 600;
  localparam int n_tests = 18;

  logic       clk;
  logic       reset;
  logic       prog_write;
  logic [6:0] prog_addr;
  logic [7:0] prog_data;
  logic [7:0] bus_address;
  logic [7:0] bus_wdata;
  logic       bus_write;

  logic [31:0] seed;
  logic [7:0]  rom_img [128];
  logic [7:0]  ram_img [128];
  int          pc;
  int          exp_cyc [$];
  logic [7:0]  exp_addr [$];
  logic [7:0]  exp_data [$];
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  cpu8_system dut0 (
    .clk         (clk),
    .reset       (reset),
    .prog_write  (prog_write),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .bus_address (bus_address),
    .bus_wdata   (bus_wdata),
    .bus_write   (bus_write)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // load plus reset plus budget for every test, then some slack
  initial begin
    #(n_tests * (budget + 140) * clk_period + 1000);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // reference results, bit 8 is carry or borrow
  function automatic logic [8:0] alu_model(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b, input logic c);
    case (op)
      4'd0: return {1'b0, a};
      4'd1: return {1'b0, b};
      4'd2: return {1'b0, a | b};
      4'd3: return {1'b0, a & b};
      4'd4: return {1'b0, a ^ b};
      4'd5: return {1'b0, a} + 9'd1;
      4'd6: return {1'b0, a} - 9'd1;
      4'd8: return {1'b0, a} + {1'b0, b} + {8'd0, c};
      4'd9: return {1'b0, a} - {1'b0, b} - {8'd0, c};
      4'd10: return {a, c};
      4'd11: return {a[0], c, a[7:1]};
      default: return 9'd0;
    endcase
  endfunction

  function automatic logic [7:0] mem_model(input logic [7:0] addr);
    return addr[7] ? rom_img[addr[6:0]] : ram_img[addr[6:0]];
  endfunction

  // instruction level model, t is the cycle of each select
  task automatic run_model();
    logic [7:0] ip, a, b, op, opnd;
    logic       c, z, taken;
    logic [8:0] y;
    int         t;
    ip = `CPU8_RESET_VECTOR;
    a = 8'd0;
    b = 8'd0;
    c = 1'b0;
    z = 1'b0;
    t = 1;
    exp_cyc.delete();
    exp_addr.delete();
    exp_data.delete();
    while (t <= budget) begin
      op = mem_model(ip);
      ip = ip + 8'd1;
      if (op[7:6] != 2'b10) begin
        if (op[7:6] == 2'b00) begin
          opnd = b;
        end else if (op[7:6] == 2'b01) begin
          opnd = mem_model(ip);
          ip = ip + 8'd1;
        end else begin
          opnd = mem_model(b);
        end
        y = alu_model(op[3:0], a, opnd, c);
        case (op[5:4])
          2'd0: a = y[7:0];
          2'd1: b = y[7:0];
          2'd2: ip = y[7:0];
          default: ;
        endcase
        if (op[3]) begin
          c = y[8];
        end
        z = (y[7:0] == 8'd0);
        t = t + 3;
      end else if (op[7:4] == 4'b1001) begin
        // strobe shows in the select after decode
        if (t + 2 <= budget) begin
          exp_cyc.push_back(t + 2);
          exp_addr.push_back({4'd0, op[3:0]});
          exp_data.push_back(a);
        end
        ram_img[op[3:0]] = a;
        t = t + 2;
      end else if (op == 8'h88) begin
        c = 1'b0;
        t = t + 2;
      end else if (op == 8'h81) begin
        opnd = a;
        a = b;
        b = opnd;
        t = t + 2;
      end else if (op[7:4] == 4'b1010) begin
        taken = (op[0] && (op[1] == c)) || (op[2] && (op[3] == z));
        ip = taken ? mem_model(ip) : ip + 8'd1;
        t = t + (taken ? 3 : 2);
      end else begin
        ip = `CPU8_RESET_VECTOR;
        t = t + 3;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic run_test(input string name);
    int qi;
    int writes;
    run_model();
    test_errors = 0;
    qi = 0;
    writes = 0;
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < 128; i++) begin
      @(negedge clk);
      prog_write = 1'b1;
      prog_addr = 7'(i);
      prog_data = rom_img[i];
    end
    @(negedge clk);
    prog_write = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    for (int cyc = 1; cyc <= budget; cyc++) begin
      @(negedge clk);
      if (qi < exp_cyc.size() && exp_cyc[qi] == cyc) begin
        if (bus_write !== 1'b1) begin
          $display("Missing write at %0t: cycle %0d should store to %h", $time, cyc,
                   exp_addr[qi]);
          test_errors++;
        end else begin
          check_value("bus_address", exp_addr[qi], bus_address);
          check_value("bus_wdata", exp_data[qi], bus_wdata);
          writes++;
        end
        qi++;
      end else if (bus_write !== 1'b0) begin
        $display("Unexpected write at %0t: cycle %0d stored to %h", $time, cyc,
                 bus_address);
        test_errors++;
      end
    end
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    errors = errors + test_errors;
    $display("%s: %0d writes checked, %0d errors", name, writes, test_errors);
  endtask

  task automatic start_rom();
    for (int i = 0; i < 128; i++) begin
      rom_img[i] = 8'(i) ^ 8'ha5;
      ram_img[i] = 8'h00;
    end
    pc = 0;
  endtask

  task automatic emit(input logic [7:0] value);
    rom_img[pc] = value;
    pc++;
  endtask

  // store A to 0 and jump back forever
  task automatic emit_tail();
    int here;
    here = pc;
    emit(8'h90);
    emit(8'h61);
    emit(8'h80 + 8'(here));
  endtask

  task automatic set_carry(input logic value);
    if (value) begin
      emit(8'h41);
      emit(8'hff);
      emit(8'h48);
      emit(8'hff);
    end else begin
      emit(8'h88);
    end
  endtask

  task automatic build_counting();
    start_rom();
    emit(8'h88);
    emit(8'h48);
    emit(8'h20);
    emit(8'h90);
    // loop while carry is clear
    emit(8'ha1);
    emit(8'h81);
    emit(8'h80);
  endtask

  task automatic build_alu_sweep();
    logic [31:0] r;
    start_rom();
    for (int op = 0; op < 12; op++) begin
      r = lcg_next();
      set_carry(r[31]);
      emit(8'h41);
      emit(r[23:16]);
      emit(8'h40 | 8'(op));
      emit(r[15:8]);
      emit(8'h90 | 8'(op));
    end
    emit_tail();
  endtask

  task automatic build_branches();
    logic [31:0] r;
    start_rom();
    for (int k = 0; k < 10; k++) begin
      r = lcg_next();
      set_carry(r[31]);
      // zero flag from a plain load
      emit(8'h41);
      emit({7'd0, r[30]});
      emit(8'ha0 | {4'd0, r[19:16]});
      emit(8'h80 + 8'(pc + 2));
      emit(8'h90 | 8'(k));
      emit(8'h9f);
    end
    emit_tail();
  endtask

  task automatic build_ram_trip();
    logic [31:0] r;
    start_rom();
    for (int k = 0; k < 8; k++) begin
      r = lcg_next();
      emit(8'h41);
      emit(r[7:0]);
      emit(8'h90 | {4'd0, r[11:8]});
      emit(8'h51);
      emit({4'd0, r[11:8]});
      emit(8'h07);
      emit(8'hc1);
      emit(8'h90 | {4'd0, r[15:12]});
    end
    emit_tail();
  endtask

  // no IP destination and no read [B], RAM may be unwritten
  task automatic build_random();
    logic [31:0] r;
    logic [1:0]  d;
    int          starts [$];
    start_rom();
    for (int k = 0; k < 40; k++) begin
      r = lcg_next();
      d = (r[21:20] == 2'd2) ? 2'd3 : r[21:20];
      starts.push_back(pc);
      case (r[31:28])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: emit({2'b00, d, r[3:0]});
        4'd5, 4'd6, 4'd7, 4'd8, 4'd9: begin
          emit({2'b01, d, r[3:0]});
          emit(r[15:8]);
        end
        4'd10, 4'd11: emit({4'b1001, r[3:0]});
        4'd12: emit(8'h88);
        4'd13: emit(8'h81);
        4'd14: begin
          emit({4'b1010, r[3:0]});
          emit(8'h80 + 8'(starts[r[15:8] % starts.size()]));
        end
        default: emit({4'b1011, r[3:0]});
      endcase
    end
    emit_tail();
  endtask

  initial begin
    reset = 1'b1;
    prog_write = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    seed = 32'h06c58bad;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (3) @(negedge clk);
    build_counting();
    run_test("counting");
    for (int i = 0; i < 3; i++) begin
      build_alu_sweep();
      run_test("alu_sweep");
    end
    for (int i = 0; i < 4; i++) begin
      build_branches();
      run_test("branches");
    end
    for (int i = 0; i < 2; i++) begin
      build_ram_trip();
      run_test("ram_round_trip");
    end
    for (int i = 0; i < 8; i++) begin
      build_random();
      run_test("random_program");
    end
    errors = errors + dut0.ctrl0.props0.failures;
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu8_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

module cpu8_properties import cpu8_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       write,
  input logic [2:0] state,
  input logic [7:0] ip
);

  int failures = 0;

  // store strobe lasts a single cycle
  write_pulse: assert property (@(posedge clk) disable iff (reset) write |=> !write)
    else begin
      $error("bus write high for two cycles in a row");
      failures++;
    end

  state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {st_reset, st_select, st_decode, st_compute, st_read_ip})
    else begin
      $error("sequencer state outside the defined states");
      failures++;
    end

  // st_reset always reloads the vector
  ip_vector: assert property (@(posedge clk) disable iff (reset)
    state == st_reset |=> ip == `CPU8_RESET_VECTOR)
    else begin
      $error("IP is not the reset vector after st_reset");
      failures++;
    end

endmodule

bind cpu8_control cpu8_properties props0 (
  .clk   (clk),
  .reset (reset),
  .write (bus.write),
  .state (state),
  .ip    (ip)
);

`default_nettype wire

/* cpu8_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

module cpu8_system (
  input  logic                                clk,
  input  logic                                reset,
  // rom load port
  input  logic                                prog_write,
  input  logic [$clog2(`CPU8_ROM_DEPTH)-1:0]  prog_addr,
  input  logic [`CPU8_DATA_W-1:0]             prog_data,
  // observed bus
  output logic [`CPU8_DATA_W-1:0]             bus_address,
  output logic [`CPU8_DATA_W-1:0]             bus_wdata,
  output logic                                bus_write
);

  cpu8_bus_if bus0 ();

  cpu8_control ctrl0 (
    .clk   (clk),
    .reset (reset),
    .bus   (bus0.cpu)
  );

  cpu8_memory mem0 (
    .clk        (clk),
    .bus        (bus0.mem),
    .prog_write (prog_write),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data)
  );

  // bus brought out for the testbench
  assign bus_address = bus0.address;
  assign bus_wdata   = bus0.wdata;
  assign bus_write   = bus0.write;

endmodule

`default_nettype wire

/* cpu8_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

module cpu8_memory (
  input  logic                                clk,
  cpu8_bus_if.mem                             bus,
  input  logic                                prog_write,
  input  logic [$clog2(`CPU8_ROM_DEPTH)-1:0]  prog_addr,
  input  logic [`CPU8_DATA_W-1:0]             prog_data
);

  localparam int rom_aw = $clog2(`CPU8_ROM_DEPTH);
  localparam int ram_aw = $clog2(`CPU8_RAM_DEPTH);

  logic [`CPU8_DATA_W-1:0] ram [`CPU8_RAM_DEPTH];
  logic [`CPU8_DATA_W-1:0] rom [`CPU8_ROM_DEPTH];

  logic                    rom_sel;
  logic [rom_aw-1:0]       rom_index;
  logic [ram_aw-1:0]       ram_index;

  // top address bit picks the rom
  assign rom_sel   = bus.address[`CPU8_DATA_W-1];
  assign rom_index = bus.address[rom_aw-1:0];
  assign ram_index = bus.address[ram_aw-1:0];

  // cpu stores land in ram only
  always_ff @(posedge clk) begin
    if (bus.write && !rom_sel) begin
      ram[ram_index] <= bus.wdata;
    end
  end

  // rom is filled from the load port, held in reset by the host
  always_ff @(posedge clk) begin
    if (prog_write) begin
      rom[prog_addr] <= prog_data;
    end
  end

  // same-cycle read at the registered address
  assign bus.rdata = rom_sel ? rom[rom_index] : ram[ram_index];

endmodule

`default_nettype wire

/* cpu8_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

module cpu8_control import cpu8_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  cpu8_bus_if.cpu       bus
);

  logic [`CPU8_DATA_W-1:0] ip;
  logic [`CPU8_DATA_W-1:0] a;
  logic [`CPU8_DATA_W-1:0] b;
  logic [`CPU8_DATA_W-1:0] opcode;
  logic                    carry;
  logic                    zero;
  seq_state_e              state;

  logic [`CPU8_DATA_W-1:0] alu_b;
  logic [`CPU8_DATA_W:0]   y;
  alu_op_e                 alu_op;
  dest_e                   dest;
  logic                    branch_taken;

  // fields of the latched opcode, used in st_compute
  assign alu_op = alu_op_e'(opcode[3:0]);
  assign dest   = dest_e'(opcode[5:4]);
  // immediate and read [B] forms take the operand from the bus
  assign alu_b  = opcode[6] ? bus.rdata : b;

  // branch test on the opcode byte as it arrives in st_decode
  assign branch_taken = (bus.rdata[0] && (bus.rdata[1] == carry)) ||
                        (bus.rdata[2] && (bus.rdata[3] == zero));

  cpu8_alu alu0 (
    .a     (a),
    .b     (alu_b),
    .op    (alu_op),
    .carry (carry),
    .y     (y)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_reset;
      ip          <= `CPU8_RESET_VECTOR;
      a           <= '0;
      b           <= '0;
      carry       <= 1'b0;
      zero        <= 1'b0;
      bus.address <= '0;
      bus.write   <= 1'b0;
    end else begin
      case (state)
        st_reset: begin
          // in-program reset touches IP only
          ip        <= `CPU8_RESET_VECTOR;
          bus.write <= 1'b0;
          state     <= st_select;
        end
        st_select: begin
          bus.address <= ip;
          ip          <= ip + 1'b1;
          // ends the store pulse from decode
          bus.write   <= 1'b0;
          state       <= st_decode;
        end
        st_decode: begin
          opcode <= bus.rdata;
          casez (bus.rdata)
            // A @ B
            8'b00??????: begin
              state <= st_compute;
            end
            // A @ immediate, fetch next byte
            8'b01??????: begin
              bus.address <= ip;
              ip          <= ip + 1'b1;
              state       <= st_compute;
            end
            // A @ read [B]
            8'b11??????: begin
              bus.address <= b;
              state       <= st_compute;
            end
            // store A, write high during next select
            8'b1001????: begin
              bus.address <= {4'b0000, bus.rdata[3:0]};
              bus.wdata   <= a;
              bus.write   <= 1'b1;
              state       <= st_select;
            end
            8'b10001000: begin
              carry <= 1'b0;
              state <= st_select;
            end
            8'b10000001: begin
              a     <= b;
              b     <= a;
              state <= st_select;
            end
            8'b1010????: begin
              if (branch_taken) begin
                bus.address <= ip;
                state       <= st_read_ip;
              end else begin
                state <= st_select;
              end
              // skip the target byte either way
              ip <= ip + 1'b1;
            end
            // every undefined opcode
            default: begin
              state <= st_reset;
            end
          endcase
        end
        st_compute: begin
          case (dest)
            dest_a:   a  <= y[`CPU8_DATA_W-1:0];
            dest_b:   b  <= y[`CPU8_DATA_W-1:0];
            dest_ip:  ip <= y[`CPU8_DATA_W-1:0];
            default:  ;
          endcase
          // carry only for opcodes 8 and up
          if (opcode[3]) begin
            carry <= y[`CPU8_DATA_W];
          end
          zero  <= ~|y[`CPU8_DATA_W-1:0];
          state <= st_select;
        end
        st_read_ip: begin
          // branch target from the byte after the opcode
          ip    <= bus.rdata;
          state <= st_select;
        end
        default: begin
          state <= st_reset;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* cpu8_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

module cpu8_alu import cpu8_pkg::*; (
  input  logic [`CPU8_DATA_W-1:0] a,
  input  logic [`CPU8_DATA_W-1:0] b,
  input  alu_op_e                 op,
  input  logic                    carry,
  output logic [`CPU8_DATA_W:0]   y
);

  logic [`CPU8_DATA_W:0] a_x;
  logic [`CPU8_DATA_W:0] b_x;
  logic [`CPU8_DATA_W:0] c_x;

  // operands widened so bit 8 catches carry or borrow
  assign a_x = {1'b0, a};
  assign b_x = {1'b0, b};
  assign c_x = {{`CPU8_DATA_W{1'b0}}, carry};

  always_comb begin
    case (op)
      op_load_a: y = a_x;
      op_load_b: y = b_x;
      op_or:     y = a_x | b_x;
      op_and:    y = a_x & b_x;
      op_xor:    y = a_x ^ b_x;
      op_inc:    y = a_x + 1'b1;
      // dec of zero sets bit 8
      op_dec:    y = a_x - 1'b1;
      op_zero:   y = '0;
      op_adc:    y = a_x + b_x + c_x;
      op_sbb:    y = a_x - b_x - c_x;
      // carry into bit 0, old bit 7 out to bit 8
      op_rol:    y = {a, carry};
      // old bit 0 out to bit 8, carry into bit 7
      op_ror:    y = {a[0], carry, a[`CPU8_DATA_W-1:1]};
      // codes 12 to 15 give zero
      default:   y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* cpu8_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu8_settings.svh"

interface cpu8_bus_if;

  logic [`CPU8_DATA_W-1:0] address;
  logic [`CPU8_DATA_W-1:0] rdata;
  logic [`CPU8_DATA_W-1:0] wdata;
  // one-cycle write pulse
  logic                    write;

  modport cpu (
    output address,
    output wdata,
    output write,
    input  rdata
  );

  // rdata is a combinational read at the registered address
  modport mem (
    input  address,
    input  wdata,
    input  write,
    output rdata
  );

endinterface

`default_nettype wire

/* cpu8_pkg.sv */
`default_nettype none

package cpu8_pkg;

  // alu operations, low nibble of a compute opcode
  typedef enum logic [3:0] {
    op_load_a = 4'h0,
    op_load_b = 4'h1,
    op_or     = 4'h2,
    op_and    = 4'h3,
    op_xor    = 4'h4,
    op_inc    = 4'h5,
    op_dec    = 4'h6,
    op_zero   = 4'h7,
    // codes from 8 up write the carry flag
    op_adc    = 4'h8,
    op_sbb    = 4'h9,
    op_rol    = 4'ha,
    op_ror    = 4'hb
  } alu_op_e;

  // compute destination, bits 5:4 of the opcode
  typedef enum logic [1:0] {
    dest_a   = 2'b00,
    dest_b   = 2'b01,
    dest_ip  = 2'b10,
    dest_nop = 2'b11
  } dest_e;

  // sequencer states
  typedef enum logic [2:0] {
    st_reset   = 3'd0,
    st_select  = 3'd1,
    st_decode  = 3'd2,
    st_compute = 3'd3,
    st_read_ip = 3'd4
  } seq_state_e;

endpackage

`default_nettype wire

/* cpu8_settings.svh */
`ifndef CPU8_SETTINGS_SVH
`define CPU8_SETTINGS_SVH

// IP loaded in the reset state, first ROM byte
`define CPU8_RESET_VECTOR 8'h80

// data and address width
`define CPU8_DATA_W 8

// address bit 7 picks rom over ram
`define CPU8_ROM_DEPTH 128
`define CPU8_RAM_DEPTH 128

`endif
